// ==== hw/nora_trace_pkg.sv ====
// shared types for the cpu bus trace path
// bus widths, raw pin bundle, trace status and record layout
// phase constants for the six-phase cpu clock, reader fsm states
`default_nettype none

package nora_trace_pkg;

    typedef logic [15:0] cpu_addr_t;    // cpu address bus
    typedef logic [7:0]  cpu_data_t;    // cpu data bus, also bank byte

    // raw cpu pins as seen at the fpga
    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t data;        // data bus, carries the bank byte while cphi2 rises
        logic      sob_mx;      // 65C02 SOB, 65C816 M/X
        logic      sync_vpa;    // 65C02 SYNC, 65C816 VPA
        logic      mln;         // memory lock, active low
        logic      vpn;         // vector pull, active low
        logic      vda;         // valid data address, 65C816 only
        logic      ef;          // emulation flag, 65C816 only
        logic      rwn;         // 1 = read
    } cpu_pins_t;

    // trace byte 0, msb first
    typedef struct packed {
        logic x;
        logic m;
        logic sync_vpa;
        logic mln;
        logic vpn;
        logic vda;
        logic ef;
        logic rwn;
    } trace_status_t;

    // one bus cycle; byte n of the record sits at bits [8n+7:8n]
    typedef struct packed {
        cpu_data_t     bank;    // byte 5
        cpu_addr_t     addr;    // bytes 4 (high) and 3 (low)
        cpu_data_t     data;    // byte 2
        cpu_data_t     spare;   // byte 1, {6'b0, x, m}
        trace_status_t status;  // byte 0
    } trace_rec_t;

    localparam int TRACE_BYTES   = 6;   // bytes per record
    localparam int PHASE_COUNT   = 6;   // clk6x cycles per cpu cycle
    localparam int PHASE_LATCH   = 3;   // cphi2 rises, address latched
    localparam int PHASE_RELEASE = 5;   // end of cycle, data latched

    typedef enum logic {
        rd_idle,
        rd_ack
    } reader_state_t;

endpackage

`default_nettype wire

// ==== hw/cpu_phaser.sv ====
// six-phase cpu clock generator
// makes cphi2 plus the latch_ad and release_wr strobes
// holds the cpu clock low at phase 0 while run is low
`timescale 1ns/1ps
`default_nettype none

module cpu_phaser
    import nora_trace_pkg::*;
(
    input  wire  clk6x,
    input  wire  reset_i,
    input  wire  run_i,         // sampled only at phase 0
    output logic cphi2_o,
    output logic latch_ad_o,    // one cycle, phase 3
    output logic release_wr_o,  // one cycle, phase 5
    output logic stopped_o      // cpu clock held
);

    localparam int PH_W = $clog2(PHASE_COUNT);

    logic [PH_W-1:0] phase_q;
    logic [PH_W-1:0] phase_next;
    logic            cphi2_q;
    logic            latch_q;
    logic            release_q;

    always_comb
    begin
        phase_next = phase_q;
        if (phase_q == PH_W'(PHASE_COUNT - 1))
        begin
            phase_next = '0;                    // wrap, cpu cycle done
        end
        else if ((phase_q != '0) || run_i)
        begin
            phase_next = phase_q + 1'b1;        // phase 0 waits for run
        end
    end

    // strobes decoded from the next phase so they line up with phase_q
    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            phase_q   <= '0;
            cphi2_q   <= 1'b0;
            latch_q   <= 1'b0;
            release_q <= 1'b0;
        end
        else
        begin
            phase_q   <= phase_next;
            cphi2_q   <= (phase_next >= PH_W'(PHASE_LATCH));    // high in phases 3..5
            latch_q   <= (phase_next == PH_W'(PHASE_LATCH));
            release_q <= (phase_next == PH_W'(PHASE_RELEASE));
        end
    end

    assign cphi2_o      = cphi2_q;          // straight from a flop, no glitches
    assign latch_ad_o   = latch_q;
    assign release_wr_o = release_q;
    assign stopped_o    = (phase_q == '0) && !run_i;

endmodule

`default_nettype wire

// ==== hw/bus_sampler.sv ====
// cpu bus sampler
// captures address, bank and status at latch_ad, data and m at release_wr
// applies the 65C02 forcing and emits one trace record per bus cycle
`timescale 1ns/1ps
`default_nettype none

module bus_sampler
    import nora_trace_pkg::*;
(
    input  wire        clk6x,
    input  wire        reset_i,
    input  wire        latch_ad_i,      // cphi2 rising
    input  wire        release_wr_i,    // end of cpu cycle
    input  wire        cputype02_i,     // 1 = 65C02, 0 = 65C816
    input  cpu_pins_t  cpu_pins_i,
    output trace_rec_t rec_o,
    output logic       rec_valid_o      // push strobe
);

    trace_rec_t rec_q;
    logic       type02_q;       // cpu type seen at latch time
    logic       valid_q;
    logic       m_next;

    // m is only valid while cphi2 falls
    // ef already carries the 65C02 forcing from latch time
    assign m_next = cpu_pins_i.sob_mx | type02_q | rec_q.status.ef;

    // payload, no reset; latch always comes before release
    always_ff @(posedge clk6x)
    begin
        if (latch_ad_i)
        begin
            type02_q  <= cputype02_i;
            rec_q.addr <= cpu_pins_i.addr;
            if (cputype02_i)
                rec_q.bank <= '0;                   // 65C02 has no bank
            else
                rec_q.bank <= cpu_pins_i.data;      // 65C816 bank on data pins
            // x valid on the rising edge, forced 8-bit in emulation
            rec_q.status.x        <= cpu_pins_i.sob_mx | cputype02_i | cpu_pins_i.ef;
            rec_q.status.sync_vpa <= cpu_pins_i.sync_vpa;
            rec_q.status.mln      <= cpu_pins_i.mln;
            rec_q.status.vpn      <= cpu_pins_i.vpn;
            rec_q.status.vda      <= cpu_pins_i.vda | cputype02_i;  // always valid on 65C02
            rec_q.status.ef       <= cpu_pins_i.ef | cputype02_i;
            rec_q.status.rwn      <= cpu_pins_i.rwn;
        end

        if (release_wr_i)
        begin
            rec_q.data     <= cpu_pins_i.data;
            rec_q.status.m <= m_next;
            rec_q.spare    <= {6'b000000, rec_q.status.x, m_next};  // copy of x and m
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
            valid_q <= 1'b0;
        else
            valid_q <= release_wr_i;    // record complete one cycle later
    end

    assign rec_o       = rec_q;
    assign rec_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== hw/trace_buffer.sv ====
// circular buffer of trace records
// oldest record shown on head_o, empty and room flags
// room stays high while two or more slots are free
`timescale 1ns/1ps
`default_nettype none

module trace_buffer
    import nora_trace_pkg::*;
#(
    parameter int TRACE_DEPTH = 8       // power of two, at least 4
)
(
    input  wire        clk6x,
    input  wire        reset_i,
    input  wire        push_i,
    input  wire        pop_i,
    input  trace_rec_t rec_i,
    output trace_rec_t head_o,
    output logic       empty_o,
    output logic       room_o
);

    localparam int PTR_W = $clog2(TRACE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    trace_rec_t       mem [TRACE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(TRACE_DEPTH));
    assign do_push = push_i && !full;   // phaser back-pressure keeps this from happening
    assign do_pop  = pop_i && (count != '0);    // pop on empty ignored

    always_ff @(posedge clk6x)
    begin
        if (do_push)
            mem[wr_ptr] <= rec_i;
    end

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    assign head_o  = mem[rd_ptr];
    assign empty_o = (count == '0);
    // two slots: one for the record in flight, one for the next cpu cycle
    assign room_o  = (count <= CNT_W'(TRACE_DEPTH - 2));

endmodule

`default_nettype wire

// ==== hw/trace_reader.sv ====
// byte-serial trace reader for the host
// req/ack handshake, one record byte per request
// pops the buffer together with the ack of the last byte
`timescale 1ns/1ps
`default_nettype none

module trace_reader
    import nora_trace_pkg::*;
(
    input  wire        clk6x,
    input  wire        reset_i,
    input  wire        host_req_i,      // level, dropped by the host after ack
    input  wire        empty_i,
    input  trace_rec_t head_i,
    output logic       host_ack_o,      // one cycle
    output logic       pop_o,           // one cycle, with the last ack
    output cpu_data_t  host_data_o      // valid with ack
);

    reader_state_t state_q;
    logic [2:0]    byte_idx;            // 0..TRACE_BYTES-1
    logic          ack_q;
    logic          pop_q;
    cpu_data_t     data_q;
    logic [47:0]   head_bits;
    logic          last_byte;

    assign head_bits = head_i;
    assign last_byte = (byte_idx == 3'(TRACE_BYTES - 1));

    always_ff @(posedge clk6x)
    begin
        // byte n of the record at bits 8n+7..8n
        if ((state_q == rd_idle) && host_req_i)
            data_q <= empty_i ? 8'hFF : head_bits[{byte_idx, 3'b000} +: 8];
    end

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            state_q  <= rd_idle;
            byte_idx <= '0;
            ack_q    <= 1'b0;
            pop_q    <= 1'b0;
        end
        else
        begin
            case (state_q)
                rd_idle:
                begin
                    if (host_req_i)
                    begin
                        state_q <= rd_ack;
                        ack_q   <= 1'b1;
                        if (!empty_i)       // empty read: 0xFF, index untouched
                        begin
                            if (last_byte)
                            begin
                                byte_idx <= '0;
                                pop_q    <= 1'b1;   // record done
                            end
                            else
                                byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                rd_ack:
                begin
                    ack_q   <= 1'b0;
                    pop_q   <= 1'b0;
                    state_q <= rd_idle;     // host has dropped req by now
                end
                default: state_q <= rd_idle;
            endcase
        end
    end

    assign host_ack_o  = ack_q;
    assign pop_o       = pop_q;
    assign host_data_o = data_q;

endmodule

`default_nettype wire

// ==== hw/nora_trace_top.sv ====
// cpu bus trace top level
// phaser paces the cpu, sampler fills the buffer, reader drains it
`timescale 1ns/1ps
`default_nettype none

module nora_trace_top
    import nora_trace_pkg::*;
#(
    parameter int TRACE_DEPTH = 8
)
(
    input  wire       clk6x,
    input  wire       reset_i,
    input  wire       cputype02_i,      // board assembly, 1 = 65C02
    input  wire       host_req_i,
    input  cpu_pins_t cpu_pins_i,
    output logic      cphi2_o,          // cpu clock
    output logic      host_ack_o,
    output cpu_data_t host_data_o
);

    logic       latch_ad;
    logic       release_wr;
    logic       room;           // also the cpu run enable
    logic       empty;
    logic       pop;
    logic       rec_valid;
    trace_rec_t rec;
    trace_rec_t head;

    cpu_phaser u_phaser (
        .clk6x        (clk6x),
        .reset_i      (reset_i),
        .run_i        (room),       // stop the cpu when nearly full
        .cphi2_o      (cphi2_o),
        .latch_ad_o   (latch_ad),
        .release_wr_o (release_wr),
        .stopped_o    ()            // no debug controller here
    );

    bus_sampler u_sampler (
        .clk6x        (clk6x),
        .reset_i      (reset_i),
        .latch_ad_i   (latch_ad),
        .release_wr_i (release_wr),
        .cputype02_i  (cputype02_i),
        .cpu_pins_i   (cpu_pins_i),
        .rec_o        (rec),
        .rec_valid_o  (rec_valid)
    );

    trace_buffer #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) u_buffer (
        .clk6x   (clk6x),
        .reset_i (reset_i),
        .push_i  (rec_valid),
        .pop_i   (pop),
        .rec_i   (rec),
        .head_o  (head),
        .empty_o (empty),
        .room_o  (room)
    );

    trace_reader u_reader (
        .clk6x       (clk6x),
        .reset_i     (reset_i),
        .host_req_i  (host_req_i),
        .empty_i     (empty),
        .head_i      (head),
        .host_ack_o  (host_ack_o),
        .pop_o       (pop),
        .host_data_o (host_data_o)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// testbench clock and reset
// free running clk6x, reset held high for the first few edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
)
(
    output logic clk6x,
    output logic reset_o
);

    initial
    begin
        clk6x = 1'b0;
        forever #(PERIOD_NS / 2) clk6x = ~clk6x;
    end

    initial
    begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk6x);
        reset_o <= 1'b0;    // released on a rising edge
    end

endmodule

`default_nettype wire

// ==== bench/trace_checker.sv ====
// trace checker for the bus trace testbench
// predicts each record from the cpu pins at the cphi2 edges
// models the host handshake and compares every byte read back
`timescale 1ns/1ps
`default_nettype none

module trace_checker
    import nora_trace_pkg::*;
(
    input  wire       clk6x,
    input  wire       reset_i,
    input  wire       cputype02_i,
    input  cpu_pins_t cpu_pins_i,
    input  wire       cphi2_i,
    input  wire       host_req_i,
    input  wire       host_ack_i,
    input  cpu_data_t host_data_i,
    output int        errors_o,
    output int        recs_read_o
);

    trace_rec_t exp_q [$];      // records the buffer should hold, oldest first
    trace_rec_t rise_rec;       // cycle in flight, latch-time fields
    trace_rec_t done_rec;       // finished cycle, pushed one clock after the fall
    logic       type02_seen;
    logic       cphi2_prev;
    logic       rst_prev;
    logic       ack_wait;       // request taken on the previous edge
    cpu_data_t  exp_byte;
    int         byte_idx;
    int         errors;
    int         recs_read;

    // record byte order: status, spare, data, addr low, addr high, bank
    function automatic cpu_data_t rec_byte(input trace_rec_t r, input int idx);
        case (idx)
            0: return r.status;
            1: return r.spare;
            2: return r.data;
            3: return r.addr[7:0];
            4: return r.addr[15:8];
            default: return r.bank;
        endcase
    endfunction

    initial
    begin
        errors    = 0;
        recs_read = 0;
    end

    always @(posedge cphi2_i)
    begin
        type02_seen = cputype02_i;
        rise_rec.addr = cpu_pins_i.addr;
        rise_rec.bank = cputype02_i ? 8'h00 : cpu_pins_i.data;     // no bank on a 65C02
        rise_rec.status.x = cpu_pins_i.sob_mx | cputype02_i | cpu_pins_i.ef;
        rise_rec.status.sync_vpa = cpu_pins_i.sync_vpa;
        rise_rec.status.mln = cpu_pins_i.mln;
        rise_rec.status.vpn = cpu_pins_i.vpn;
        rise_rec.status.vda = cpu_pins_i.vda | cputype02_i;
        rise_rec.status.ef = cpu_pins_i.ef | cputype02_i;
        rise_rec.status.rwn = cpu_pins_i.rwn;
    end

    always @(negedge cphi2_i)
    begin
        done_rec = rise_rec;
        done_rec.data = cpu_pins_i.data;    // data valid at the fall
        done_rec.status.m = cpu_pins_i.sob_mx | type02_seen | done_rec.status.ef;
        done_rec.spare = {6'b000000, done_rec.status.x, done_rec.status.m};
    end

    always @(posedge clk6x)
    begin
        if (reset_i)
        begin
            exp_q.delete();
            byte_idx   = 0;
            ack_wait   = 1'b0;
            cphi2_prev = 1'b0;
            rst_prev   = 1'b1;
        end
        else
        begin
            if (rst_prev && (cphi2_i !== 1'b0))
            begin
                errors++;
                $display("FAIL cphi2_o after reset: got %h, expected %h", cphi2_i, 1'b0);
            end
            rst_prev = 1'b0;
            // ack exactly one clock after the request was taken
            if (host_ack_i !== ack_wait)
            begin
                errors++;
                $display("FAIL host_ack_o: got %h, expected %h", host_ack_i, ack_wait);
            end
            else if (ack_wait && (host_data_i !== exp_byte))
            begin
                errors++;
                $display("FAIL host_data_o: got %h, expected %h", host_data_i, exp_byte);
            end
            if (ack_wait)
                ack_wait = 1'b0;                // reader busy acking, req ignored
            else if (host_req_i)
            begin
                ack_wait = 1'b1;
                if (exp_q.size() == 0)
                    exp_byte = 8'hFF;           // empty read, nothing consumed
                else
                begin
                    exp_byte = rec_byte(exp_q[0], byte_idx);
                    if (byte_idx == TRACE_BYTES - 1)
                    begin
                        exp_q.delete(0);
                        byte_idx = 0;
                        recs_read++;
                    end
                    else
                        byte_idx++;
                end
            end
            if (cphi2_prev && !cphi2_i)
                exp_q.push_back(done_rec);      // cphi2 fell on the last edge
            cphi2_prev = cphi2_i;
        end
    end

    assign errors_o    = errors;
    assign recs_read_o = recs_read;

endmodule

`default_nettype wire

// ==== bench/tb_nora_trace.sv ====
// testbench top for the cpu bus trace path
// stimulus table with host read pattern, lcg fill rows, host reads, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_nora_trace
    import nora_trace_pkg::*;
();

    localparam int CLK_NS      = 20;
    localparam int DEPTH       = 8;
    localparam int NROWS       = 16;
    localparam int STOP_QUIET  = 3 * PHASE_COUNT;          // clocks without a cphi2 edge
    localparam int STOP_LIMIT  = 4 * DEPTH * PHASE_COUNT;
    localparam int WATCHDOG_NS = NROWS * 200 * CLK_NS;     // 200 clocks per row

    typedef struct packed {
        logic       type02;
        cpu_pins_t  rise;       // data carries the bank
        logic       fall_sob;
        cpu_data_t  fall_data;
        logic       hold;       // host idle until the cpu clock stops
        logic [7:0] reads;      // host byte reads after this cycle
    } stim_row_t;

    logic        clk6x;
    logic        reset;
    logic        type02;
    logic        host_req;
    cpu_pins_t   pins;
    logic        cphi2;
    logic        host_ack;
    cpu_data_t   host_data;
    int          rows_done;
    int          host_errors;
    int          chk_errors;
    int          recs_read;
    int unsigned seed;
    stim_row_t   stim_table [NROWS];

    tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) u_clock (.clk6x(clk6x), .reset_o(reset));

    nora_trace_top #(.TRACE_DEPTH(DEPTH)) UUT (
        .clk6x       (clk6x),
        .reset_i     (reset),
        .cputype02_i (type02),
        .host_req_i  (host_req),
        .cpu_pins_i  (pins),
        .cphi2_o     (cphi2),
        .host_ack_o  (host_ack),
        .host_data_o (host_data)
    );

    trace_checker u_check (
        .clk6x       (clk6x),
        .reset_i     (reset),
        .cputype02_i (type02),
        .cpu_pins_i  (pins),
        .cphi2_i     (cphi2),
        .host_req_i  (host_req),
        .host_ack_i  (host_ack),
        .host_data_i (host_data),
        .errors_o    (chk_errors),
        .recs_read_o (recs_read)
    );

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // flags are sync_vpa, mln, vpn, vda, ef, rwn
    function automatic stim_row_t fixed_row(input logic t02, input cpu_addr_t addr,
            input cpu_data_t bank, input logic [5:0] flags, input logic rise_sob,
            input logic fall_sob, input cpu_data_t fall_data, input int reads);
        stim_row_t r;
        r.type02 = t02;
        r.rise.addr = addr;
        r.rise.data = bank;
        r.rise.sob_mx = rise_sob;
        {r.rise.sync_vpa, r.rise.mln, r.rise.vpn, r.rise.vda, r.rise.ef, r.rise.rwn} = flags;
        r.fall_sob = fall_sob;
        r.fall_data = fall_data;
        r.hold = 1'b0;
        r.reads = 8'(reads);
        return r;
    endfunction

    task automatic build_table;
        int unsigned r;
        stim_table[0] = fixed_row(1'b0, 16'h1234, 8'h7E, 6'b111101, 1'b0, 1'b1, 8'hA5, 0);
        stim_table[1] = fixed_row(1'b0, 16'hFFFC, 8'h00, 6'b010111, 1'b0, 1'b0, 8'h34, 0);
        stim_table[2] = fixed_row(1'b1, 16'h8000, 8'h55, 6'b101000, 1'b0, 1'b0, 8'hC3, 0);
        stim_table[3] = fixed_row(1'b0, 16'h00FF, 8'h12, 6'b011100, 1'b1, 1'b0, 8'h5A, 6);
        seed = 46;
        for (int i = 4; i < NROWS; i++)
        begin
            seed = lcg_next(seed);
            r = seed;
            seed = lcg_next(seed);
            stim_table[i].rise      = r[31:2];     // upper bits, low lcg bits are weak
            stim_table[i].type02    = seed[31];
            stim_table[i].fall_sob  = seed[30];
            stim_table[i].fall_data = seed[23:16];
            stim_table[i].hold      = (i == 4);
            stim_table[i].reads     = (i == 4) ? 8'd36 : ((i < 14) ? 8'd6 : 8'd0);
        end
    endtask

    task automatic read_byte;
        @(posedge clk6x);
        host_req <= 1'b1;
        @(posedge host_ack);
        host_req <= 1'b0;   // drop req in the ack cycle
    endtask

    task automatic wait_cpu_stop;
        int   quiet;
        int   waited;
        logic last;
        quiet  = 0;
        waited = 0;
        last   = cphi2;
        while ((quiet < STOP_QUIET) && (waited < STOP_LIMIT))
        begin
            @(negedge clk6x);
            waited++;
            quiet = (cphi2 === last) ? quiet + 1 : 0;
            last  = cphi2;
        end
        if (quiet < STOP_QUIET)
        begin
            host_errors++;
            $display("cpu clock still toggling %0d clocks after the host went idle", waited);
        end
        else if (cphi2 !== 1'b0)
        begin
            host_errors++;
            $display("FAIL cphi2_o while stopped: got %h, expected %h", cphi2, 1'b0);
        end
    endtask

    // bus side, pins follow the cpu clock edges
    initial
    begin
        wait (!reset);
        @(posedge clk6x);
        for (int i = 0; i < NROWS; i++)
        begin
            type02 <= stim_table[i].type02;
            pins   <= stim_table[i].rise;
            @(posedge cphi2);
            @(posedge clk6x);                   // address latched on this edge
            pins.sob_mx <= stim_table[i].fall_sob;
            pins.data   <= stim_table[i].fall_data;
            @(negedge cphi2);
            rows_done = i + 1;
        end
    end

    // host side and end of run
    initial
    begin
        type02      = 1'b0;
        host_req    = 1'b0;
        pins        = '0;
        rows_done   = 0;
        host_errors = 0;
        build_table();
        wait (!reset);
        read_byte();                            // buffer still empty
        for (int i = 0; i < NROWS; i++)
        begin
            wait (rows_done > i);
            if (stim_table[i].hold)
                wait_cpu_stop();
            repeat (stim_table[i].reads) read_byte();
        end
        while (recs_read < NROWS)
            read_byte();
        repeat (2) @(posedge clk6x);            // last ack compared
        $display("errors: checker %0d, host %0d, records read %0d",
                 chk_errors, host_errors, recs_read);
        if ((chk_errors + host_errors) == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/nora_trace_pkg.sv
hw/cpu_phaser.sv
hw/bus_sampler.sv
hw/trace_buffer.sv
hw/trace_reader.sv
hw/nora_trace_top.sv
bench/tb_clock.sv
bench/trace_checker.sv
bench/tb_nora_trace.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the trace testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module tb_nora_trace -o sim_nora_trace
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_nora_trace)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
